/* verilog.f */
+incdir+src
src/axi_pkg.sv
src/axi_arbiter.sv
src/axi_xbar.sv
src/sram_slave.sv
src/clint_timer.sv
src/mem_subsystem_top.sv
verification/mem_subsystem_asserts.sv
verification/mem_subsystem_tb.sv

/* verification/mem_subsystem_tb.sv */
//*************************************************
// mem_subsystem_tb: fetch and load/store traffic
// against a reference memory, with a watchdog
//*************************************************
`timescale 1ns/1ps
`include "axi_settings.svh"

module mem_subsystem_tb;
	import axi_pkg::*;

	// fill, readback, strobes, same-cycle pairs, timer, back-pressure, random mix
	localparam int N_TRANS = 256 + 256 + 64 + 16 + 4 + 40 + 2 * 200;
	localparam int IDX_W   = $clog2(`SRAM_WORDS);
	localparam addr_t TIMER_ADDR = {`CLINT_BASE, 16'h0000};

	logic      clock = 1'b0;
	logic      reset;
	addr_req_t inst_ar_i, data_ar_i, data_aw_i;
	wdata_t    data_w_i;
	logic      inst_ar_valid_i, data_ar_valid_i, data_aw_valid_i, data_w_valid_i;
	logic      inst_ar_ready_o, data_ar_ready_o, data_aw_ready_o, data_w_ready_o;
	rdata_t    inst_r_o, data_r_o;
	resp_t     data_b_o;
	logic      inst_r_valid_o, data_r_valid_o, data_b_valid_o;
	logic      inst_r_ready_i, data_r_ready_i, data_b_ready_i;

	data_t  ref_mem [`SRAM_WORDS];
	rdata_t exp_data_r[$];
	bit     exp_timer[$];          // matching entry is a CLINT read
	rdata_t exp_inst_r[$];
	resp_t  exp_b[$];
	data_t  timer_last = '0;
	time    data_resp_time, inst_resp_time;
	bit     bp_on = 1'b0;
	bit     data_r_held, inst_r_held;
	rdata_t data_r_last, inst_r_last;

	mem_subsystem_top DUT (.*);

	always #20 clock = ~clock;

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic compare_rdata(string name, rdata_t exp, rdata_t act);
		if (act !== exp)
			stop_on_error($sformatf("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act));
	endtask

	task automatic compare_resp(string name, resp_t exp, resp_t act);
		if (act !== exp)
			stop_on_error($sformatf("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act));
	endtask

	// byte lanes with a strobe bit take the new data
	function automatic data_t merge_strobed(data_t old, data_t wr, strb_t strb);
		data_t res;
		res = old;
		for (int i = 0; i < `AXI_DATA_W / 8; i++) begin
			if (strb[i])
				res[8*i +: 8] = wr[8*i +: 8];
		end
		return res;
	endfunction

	function automatic int word_index(addr_t a);
		return int'(a[IDX_W+1:2]);   // SRAM wraps on the word bits
	endfunction

	function automatic bit is_timer(addr_t a);
		return a[`AXI_ADDR_W-1 -: 16] == `CLINT_BASE;
	endfunction

	function automatic addr_t rand_sram_addr();
		return addr_t'($urandom) & 32'h0000_FFFC;
	endfunction

	task automatic store(addr_t a, data_t d, strb_t s);
		@(posedge clock);
		data_aw_i       <= '{addr: a, size: 3'd2};
		data_w_i        <= '{data: d, strb: s};
		data_aw_valid_i <= 1'b1;
		data_w_valid_i  <= 1'b1;
		do @(posedge clock); while (!data_aw_ready_o);
		if (!data_w_ready_o)
			stop_on_error("write data not accepted together with the write address");
		data_aw_valid_i <= 1'b0;
		data_w_valid_i  <= 1'b0;
		if (is_timer(a)) begin
			exp_b.push_back(`RESP_SLVERR);
		end else begin
			exp_b.push_back(`RESP_OKAY);
			ref_mem[word_index(a)] = merge_strobed(ref_mem[word_index(a)], d, s);
		end
	endtask

	task automatic load(addr_t a);
		@(posedge clock);
		data_ar_i       <= '{addr: a, size: 3'd2};
		data_ar_valid_i <= 1'b1;
		do @(posedge clock); while (!data_ar_ready_o);
		data_ar_valid_i <= 1'b0;
		exp_timer.push_back(is_timer(a));
		exp_data_r.push_back('{data: ref_mem[word_index(a)], resp: `RESP_OKAY});
	endtask

	task automatic fetch(addr_t a);
		@(posedge clock);
		inst_ar_i       <= '{addr: a, size: 3'd2};
		inst_ar_valid_i <= 1'b1;
		do @(posedge clock); while (!inst_ar_ready_o);
		inst_ar_valid_i <= 1'b0;
		exp_inst_r.push_back('{data: ref_mem[word_index(a)], resp: `RESP_OKAY});
	endtask

	task automatic drain();
		while (exp_data_r.size() != 0 || exp_inst_r.size() != 0 || exp_b.size() != 0)
			@(posedge clock);
	endtask

	// response readies, random when back-pressure is on
	initial begin
		inst_r_ready_i = 1'b0;
		data_r_ready_i = 1'b0;
		data_b_ready_i = 1'b0;
		forever begin
			@(posedge clock);
			inst_r_ready_i <= !bp_on || ($urandom_range(3) == 0);
			data_r_ready_i <= !bp_on || ($urandom_range(3) == 0);
			data_b_ready_i <= !bp_on || ($urandom_range(3) == 0);
		end
	end

	always @(posedge clock) begin
		rdata_t exp_r;
		bit     timer_rd;
		if (!reset) begin
			// a stalled response must hold until taken
			if (data_r_held && !data_r_valid_o)
				stop_on_error("data read response dropped before it was accepted");
			if (data_r_held)
				compare_rdata("data_r_o", data_r_last, data_r_o);
			if (inst_r_held && !inst_r_valid_o)
				stop_on_error("fetch response dropped before it was accepted");
			if (inst_r_held)
				compare_rdata("inst_r_o", inst_r_last, inst_r_o);
			if (data_r_valid_o && data_r_ready_i) begin
				if (exp_data_r.size() == 0)
					stop_on_error("data read response arrived with no load outstanding");
				exp_r    = exp_data_r.pop_front();
				timer_rd = exp_timer.pop_front();
				if (timer_rd) begin
					compare_resp("data_r_o.resp", `RESP_OKAY, data_r_o.resp);
					if (data_r_o.data <= timer_last)
						stop_on_error($sformatf("ERR time=%0t data_r_o.data expected above %h actual=%h",
							$time, timer_last, data_r_o.data));
					timer_last = data_r_o.data;
				end else begin
					compare_rdata("data_r_o", exp_r, data_r_o);
				end
				data_resp_time = $time;
			end
			if (inst_r_valid_o && inst_r_ready_i) begin
				if (exp_inst_r.size() == 0)
					stop_on_error("fetch response arrived with no fetch outstanding");
				compare_rdata("inst_r_o", exp_inst_r.pop_front(), inst_r_o);
				inst_resp_time = $time;
			end
			if (data_b_valid_o && data_b_ready_i) begin
				if (exp_b.size() == 0)
					stop_on_error("write response arrived with no store outstanding");
				compare_resp("data_b_o", exp_b.pop_front(), data_b_o);
			end
			data_r_held = data_r_valid_o && !data_r_ready_i;
			data_r_last = data_r_o;
			inst_r_held = inst_r_valid_o && !inst_r_ready_i;
			inst_r_last = inst_r_o;
		end
	end

	always @(posedge clock) begin
		if (DUT.u_arbiter.u_asserts.assert_errors != 0)
			stop_on_error("an arbiter assertion failed");
	end

	initial begin
		repeat (N_TRANS * 64 + 1000) @(posedge clock);
		stop_on_error("watchdog expired before all transactions completed");
	end

	initial begin
		addr_t a;
		addr_t b;
		void'($urandom(19));
		reset           = 1'b1;
		inst_ar_i       = '0;
		data_ar_i       = '0;
		data_aw_i       = '0;
		data_w_i        = '0;
		inst_ar_valid_i = 1'b0;
		data_ar_valid_i = 1'b0;
		data_aw_valid_i = 1'b0;
		data_w_valid_i  = 1'b0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		// full-word fill, pattern from the whole address
		for (int i = 0; i < `SRAM_WORDS; i++) begin
			a = addr_t'(i * 4);
			store(a, (a * 32'h9E37_79B1) ^ 32'h0F1E_2D3C, 4'hF);
		end
		for (int i = 0; i < `SRAM_WORDS; i++)
			load(addr_t'(i * 4));
		drain();

		for (int i = 0; i < 32; i++) begin
			a = rand_sram_addr();
			store(a, data_t'($urandom), strb_t'($urandom));
			load(a);
		end
		drain();

		// same-cycle requests, load must finish first
		for (int i = 0; i < 8; i++) begin
			a = rand_sram_addr();
			b = rand_sram_addr();
			fork
				load(a);
				fetch(b);
			join
			drain();
			if (inst_resp_time <= data_resp_time)
				stop_on_error("fetch response completed before the load response");
		end

		load(TIMER_ADDR);
		load(TIMER_ADDR);
		store(TIMER_ADDR, 32'hFFFF_FFFF, 4'hF);   // must not reach SRAM word 0
		load(32'h0000_0000);
		drain();

		bp_on <= 1'b1;
		for (int i = 0; i < 20; i++) begin
			load(rand_sram_addr());
			fetch(rand_sram_addr());
		end
		drain();

		for (int i = 0; i < 200; i++) begin
			a = rand_sram_addr();
			b = rand_sram_addr();
			case ($urandom_range(3))
				0: store(a, data_t'($urandom), strb_t'($urandom));
				1: load(a);
				2: fetch(a);
				default: begin
					fork
						load(a);
						fetch(b);
					join
				end
			endcase
		end
		drain();

		if (DUT.u_arbiter.u_asserts.assert_errors != 0) begin
			stop_on_error("an arbiter assertion failed");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

/* verification/mem_subsystem_asserts.sv */
//*************************************************
// mem_subsystem_asserts: arbiter protocol checks,
// bound into every axi_arbiter
//*************************************************
`timescale 1ns/1ps

module mem_subsystem_asserts (
	input logic                  clock,
	input logic                  reset,
	input axi_pkg::arb_state_t   state_q,
	input logic                  inst_r_valid_o, data_r_valid_o, data_b_valid_o,
	input logic                  inst_ar_ready_o, data_ar_ready_o, data_aw_ready_o,
	input axi_pkg::device_t      device_sel_o
);
	import axi_pkg::*;

	int assert_errors = 0;   // failures seen so far

	// only the owner may see a response
	one_owner_resp: assert property (@(posedge clock) disable iff (reset)
		!(inst_r_valid_o && (data_r_valid_o || data_b_valid_o)))
	else begin
		assert_errors++;
		$error("fetch and load/store responses valid in the same cycle");
	end

	no_grant_when_busy: assert property (@(posedge clock) disable iff (reset)
		(state_q != ARB_IDLE) |-> !(inst_ar_ready_o || data_ar_ready_o || data_aw_ready_o))
	else begin
		assert_errors++;
		$error("address ready given while a transaction is in flight");
	end

	// held target matches the decode of the granting cycle
	device_held: assert property (@(posedge clock) disable iff (reset)
		(state_q != ARB_IDLE) |-> $stable(device_sel_o))
	else begin
		assert_errors++;
		$error("device select changed during a transaction");
	end

endmodule

bind axi_arbiter mem_subsystem_asserts u_asserts (
	.clock(clock), .reset(reset), .state_q(state_q),
	.inst_r_valid_o(inst_r_valid_o), .data_r_valid_o(data_r_valid_o),
	.data_b_valid_o(data_b_valid_o), .inst_ar_ready_o(inst_ar_ready_o),
	.data_ar_ready_o(data_ar_ready_o), .data_aw_ready_o(data_aw_ready_o),
	.device_sel_o(device_sel_o)
);

/* src/mem_subsystem_top.sv */
//*************************************************
// mem_subsystem_top: arbiter, xbar, SRAM and CLINT
//*************************************************
`timescale 1ns/1ps

module mem_subsystem_top (
	input  logic               clock,
	input  logic               reset,
	input  axi_pkg::addr_req_t inst_ar_i, data_ar_i, data_aw_i,
	input  axi_pkg::wdata_t    data_w_i,
	input  logic               inst_ar_valid_i, data_ar_valid_i, data_aw_valid_i, data_w_valid_i,
	output logic               inst_ar_ready_o, data_ar_ready_o, data_aw_ready_o, data_w_ready_o,
	output axi_pkg::rdata_t    inst_r_o, data_r_o,
	output axi_pkg::resp_t     data_b_o,
	output logic               inst_r_valid_o, data_r_valid_o, data_b_valid_o,
	input  logic               inst_r_ready_i, data_r_ready_i, data_b_ready_i
);
	import axi_pkg::*;

	device_t   device_sel;
	addr_req_t slv_ar, slv_aw, sram_ar, sram_aw, clint_ar, clint_aw;
	wdata_t    slv_w, sram_w, clint_w;
	rdata_t    slv_r, sram_r, clint_r;
	resp_t     slv_b, sram_b, clint_b;
	logic      slv_ar_valid, slv_aw_valid, slv_w_valid, slv_r_valid, slv_b_valid;
	logic      slv_ar_ready, slv_aw_ready, slv_w_ready, slv_r_ready, slv_b_ready;
	logic      sram_ar_valid, sram_aw_valid, sram_w_valid, sram_r_valid, sram_b_valid;
	logic      sram_ar_ready, sram_aw_ready, sram_w_ready, sram_r_ready, sram_b_ready;
	logic      clint_ar_valid, clint_aw_valid, clint_w_valid, clint_r_valid, clint_b_valid;
	logic      clint_ar_ready, clint_aw_ready, clint_w_ready, clint_r_ready, clint_b_ready;

	// master ports share their names with the top ports
	axi_arbiter u_arbiter (
		.*,
		.slv_ar_o(slv_ar), .slv_ar_valid_o(slv_ar_valid), .slv_ar_ready_i(slv_ar_ready),
		.slv_aw_o(slv_aw), .slv_aw_valid_o(slv_aw_valid), .slv_aw_ready_i(slv_aw_ready),
		.slv_w_o(slv_w), .slv_w_valid_o(slv_w_valid), .slv_w_ready_i(slv_w_ready),
		.slv_r_i(slv_r), .slv_r_valid_i(slv_r_valid), .slv_r_ready_o(slv_r_ready),
		.slv_b_i(slv_b), .slv_b_valid_i(slv_b_valid), .slv_b_ready_o(slv_b_ready),
		.device_sel_o(device_sel)
	);

	axi_xbar u_xbar (
		.device_sel_i(device_sel),
		.slv_ar_i(slv_ar), .slv_aw_i(slv_aw), .slv_w_i(slv_w),
		.slv_ar_valid_i(slv_ar_valid), .slv_aw_valid_i(slv_aw_valid), .slv_w_valid_i(slv_w_valid),
		.slv_ar_ready_o(slv_ar_ready), .slv_aw_ready_o(slv_aw_ready), .slv_w_ready_o(slv_w_ready),
		.slv_r_o(slv_r), .slv_r_valid_o(slv_r_valid), .slv_r_ready_i(slv_r_ready),
		.slv_b_o(slv_b), .slv_b_valid_o(slv_b_valid), .slv_b_ready_i(slv_b_ready),
		.sram_ar_o(sram_ar), .sram_aw_o(sram_aw), .sram_w_o(sram_w),
		.sram_ar_valid_o(sram_ar_valid), .sram_aw_valid_o(sram_aw_valid),
		.sram_w_valid_o(sram_w_valid),
		.sram_ar_ready_i(sram_ar_ready), .sram_aw_ready_i(sram_aw_ready),
		.sram_w_ready_i(sram_w_ready),
		.sram_r_i(sram_r), .sram_r_valid_i(sram_r_valid), .sram_r_ready_o(sram_r_ready),
		.sram_b_i(sram_b), .sram_b_valid_i(sram_b_valid), .sram_b_ready_o(sram_b_ready),
		.clint_ar_o(clint_ar), .clint_aw_o(clint_aw), .clint_w_o(clint_w),
		.clint_ar_valid_o(clint_ar_valid), .clint_aw_valid_o(clint_aw_valid),
		.clint_w_valid_o(clint_w_valid),
		.clint_ar_ready_i(clint_ar_ready), .clint_aw_ready_i(clint_aw_ready),
		.clint_w_ready_i(clint_w_ready),
		.clint_r_i(clint_r), .clint_r_valid_i(clint_r_valid), .clint_r_ready_o(clint_r_ready),
		.clint_b_i(clint_b), .clint_b_valid_i(clint_b_valid), .clint_b_ready_o(clint_b_ready)
	);

	sram_slave u_sram (
		.clock(clock), .reset(reset),
		.ar_i(sram_ar), .aw_i(sram_aw), .w_i(sram_w),
		.ar_valid_i(sram_ar_valid), .aw_valid_i(sram_aw_valid), .w_valid_i(sram_w_valid),
		.ar_ready_o(sram_ar_ready), .aw_ready_o(sram_aw_ready), .w_ready_o(sram_w_ready),
		.r_o(sram_r), .b_o(sram_b), .r_valid_o(sram_r_valid), .b_valid_o(sram_b_valid),
		.r_ready_i(sram_r_ready), .b_ready_i(sram_b_ready)
	);

	clint_timer u_clint (
		.clock(clock), .reset(reset),
		.ar_i(clint_ar), .aw_i(clint_aw), .w_i(clint_w),
		.ar_valid_i(clint_ar_valid), .aw_valid_i(clint_aw_valid), .w_valid_i(clint_w_valid),
		.ar_ready_o(clint_ar_ready), .aw_ready_o(clint_aw_ready), .w_ready_o(clint_w_ready),
		.r_o(clint_r), .b_o(clint_b), .r_valid_o(clint_r_valid), .b_valid_o(clint_b_valid),
		.r_ready_i(clint_r_ready), .b_ready_i(clint_b_ready)
	);

endmodule

/* src/clint_timer.sv */
//*************************************************
// clint_timer: free-running 64-bit mtime, read as
// two words, writes refused with SLVERR
//*************************************************
`timescale 1ns/1ps
`include "axi_settings.svh"

module clint_timer (
	input  logic               clock,
	input  logic               reset,
	input  axi_pkg::addr_req_t ar_i, aw_i,
	input  axi_pkg::wdata_t    w_i,
	input  logic               ar_valid_i, aw_valid_i, w_valid_i,
	output logic               ar_ready_o, aw_ready_o, w_ready_o,
	output axi_pkg::rdata_t    r_o,
	output axi_pkg::resp_t     b_o,
	output logic               r_valid_o, b_valid_o,
	input  logic               r_ready_i, b_ready_i
);
	import axi_pkg::*;

	logic [63:0] mtime_q;
	data_t       rdata_q;
	logic        r_valid_q;
	logic        b_valid_q;
	logic        idle;
	logic        wr_fire;
	logic        rd_fire;

	assign idle = ~r_valid_q & ~b_valid_q;

	assign ar_ready_o = idle;
	assign aw_ready_o = idle;
	assign w_ready_o  = idle;

	assign wr_fire = idle & aw_valid_i & w_valid_i;   // aw_i and w_i are dropped
	assign rd_fire = idle & ar_valid_i & ~wr_fire;

	assign r_o       = '{data: rdata_q, resp: `RESP_OKAY};
	assign r_valid_o = r_valid_q;
	assign b_o       = `RESP_SLVERR;    // mtime is read only here
	assign b_valid_o = b_valid_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime_q   <= '0;
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			mtime_q <= mtime_q + 64'd1;
			if (rd_fire)
				r_valid_q <= 1'b1;
			else if (r_valid_q && r_ready_i)
				r_valid_q <= 1'b0;
			if (wr_fire)
				b_valid_q <= 1'b1;
			else if (b_valid_q && b_ready_i)
				b_valid_q <= 1'b0;
		end
	end

	// offset 0 is the low word, anything else the high word
	always_ff @(posedge clock) begin
		if (rd_fire)
			rdata_q <= (ar_i.addr[15:0] == 16'h0) ? mtime_q[31:0] : mtime_q[63:32];
	end

endmodule

/* src/sram_slave.sv */
//*************************************************
// sram_slave: word memory with byte strobes and a
// fixed response latency
//*************************************************
`timescale 1ns/1ps
`include "axi_settings.svh"

module sram_slave (
	input  logic               clock,
	input  logic               reset,
	input  axi_pkg::addr_req_t ar_i, aw_i,
	input  axi_pkg::wdata_t    w_i,
	input  logic               ar_valid_i, aw_valid_i, w_valid_i,
	output logic               ar_ready_o, aw_ready_o, w_ready_o,
	output axi_pkg::rdata_t    r_o,
	output axi_pkg::resp_t     b_o,
	output logic               r_valid_o, b_valid_o,
	input  logic               r_ready_i, b_ready_i
);
	import axi_pkg::*;

	localparam int IDX_W = $clog2(`SRAM_WORDS);
	localparam int CNT_W = $clog2(`SRAM_LATENCY + 1);

	data_t            mem [`SRAM_WORDS];
	data_t            rdata_q;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	logic [CNT_W-1:0] cnt_q;       // cycles left before the response
	logic             busy_q;
	logic             is_wr_q;
	logic             resp_q;
	logic             wr_fire;
	logic             rd_fire;

	// one access in flight, nothing accepted until it is answered
	assign ar_ready_o = ~busy_q;
	assign aw_ready_o = ~busy_q;
	assign w_ready_o  = ~busy_q;

	assign wr_fire = ~busy_q & aw_valid_i & w_valid_i;
	assign rd_fire = ~busy_q & ar_valid_i & ~wr_fire;

	// word index, upper address bits wrap
	assign wr_idx = aw_i.addr[IDX_W+1:2];
	assign rd_idx = ar_i.addr[IDX_W+1:2];

	assign r_o       = '{data: rdata_q, resp: `RESP_OKAY};
	assign r_valid_o = resp_q & ~is_wr_q;
	assign b_o       = `RESP_OKAY;
	assign b_valid_o = resp_q & is_wr_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q  <= 1'b0;
			is_wr_q <= 1'b0;
			resp_q  <= 1'b0;
			cnt_q   <= '0;
		end else if (!busy_q) begin
			if (wr_fire || rd_fire) begin
				busy_q  <= 1'b1;
				is_wr_q <= wr_fire;
				cnt_q   <= CNT_W'(`SRAM_LATENCY - 1);
			end
		end else if (!resp_q) begin
			if (cnt_q == '0)
				resp_q <= 1'b1;
			else
				cnt_q <= cnt_q - 1'b1;
		end else if ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i)) begin
			busy_q <= 1'b0;    // response taken
			resp_q <= 1'b0;
		end
	end

	// array write merges lanes, read word is captured at accept
	always_ff @(posedge clock) begin
		if (wr_fire) begin
			for (int i = 0; i < `AXI_DATA_W/8; i++) begin
				if (w_i.strb[i])
					mem[wr_idx][8*i +: 8] <= w_i.data[8*i +: 8];
			end
		end
		if (rd_fire)
			rdata_q <= mem[rd_idx];
	end

endmodule

/* src/axi_xbar.sv */
//*************************************************
// axi_xbar: steers the granted path to the SRAM or
// the CLINT and returns that device's answers
//*************************************************
`timescale 1ns/1ps

module axi_xbar (
	input  axi_pkg::device_t   device_sel_i,
	// arbiter side
	input  axi_pkg::addr_req_t slv_ar_i, slv_aw_i,
	input  axi_pkg::wdata_t    slv_w_i,
	input  logic               slv_ar_valid_i, slv_aw_valid_i, slv_w_valid_i,
	output logic               slv_ar_ready_o, slv_aw_ready_o, slv_w_ready_o,
	output axi_pkg::rdata_t    slv_r_o,
	output axi_pkg::resp_t     slv_b_o,
	output logic               slv_r_valid_o, slv_b_valid_o,
	input  logic               slv_r_ready_i, slv_b_ready_i,
	// SRAM side
	output axi_pkg::addr_req_t sram_ar_o, sram_aw_o,
	output axi_pkg::wdata_t    sram_w_o,
	output logic               sram_ar_valid_o, sram_aw_valid_o, sram_w_valid_o,
	input  logic               sram_ar_ready_i, sram_aw_ready_i, sram_w_ready_i,
	input  axi_pkg::rdata_t    sram_r_i,
	input  axi_pkg::resp_t     sram_b_i,
	input  logic               sram_r_valid_i, sram_b_valid_i,
	output logic               sram_r_ready_o, sram_b_ready_o,
	// CLINT side
	output axi_pkg::addr_req_t clint_ar_o, clint_aw_o,
	output axi_pkg::wdata_t    clint_w_o,
	output logic               clint_ar_valid_o, clint_aw_valid_o, clint_w_valid_o,
	input  logic               clint_ar_ready_i, clint_aw_ready_i, clint_w_ready_i,
	input  axi_pkg::rdata_t    clint_r_i,
	input  axi_pkg::resp_t     clint_b_i,
	input  logic               clint_r_valid_i, clint_b_valid_i,
	output logic               clint_r_ready_o, clint_b_ready_o
);
	import axi_pkg::*;

	logic to_clint;

	assign to_clint = (device_sel_i == DEV_CLINT);

	// payloads fan out to both, the valids decide who sees a beat
	assign sram_ar_o  = slv_ar_i;
	assign sram_aw_o  = slv_aw_i;
	assign sram_w_o   = slv_w_i;
	assign clint_ar_o = slv_ar_i;
	assign clint_aw_o = slv_aw_i;
	assign clint_w_o  = slv_w_i;

	assign sram_ar_valid_o  = slv_ar_valid_i & ~to_clint;
	assign sram_aw_valid_o  = slv_aw_valid_i & ~to_clint;
	assign sram_w_valid_o   = slv_w_valid_i & ~to_clint;
	assign clint_ar_valid_o = slv_ar_valid_i & to_clint;
	assign clint_aw_valid_o = slv_aw_valid_i & to_clint;
	assign clint_w_valid_o  = slv_w_valid_i & to_clint;

	assign slv_ar_ready_o = to_clint ? clint_ar_ready_i : sram_ar_ready_i;
	assign slv_aw_ready_o = to_clint ? clint_aw_ready_i : sram_aw_ready_i;
	assign slv_w_ready_o  = to_clint ? clint_w_ready_i : sram_w_ready_i;

	// response mux back to the arbiter
	assign slv_r_o       = to_clint ? clint_r_i : sram_r_i;
	assign slv_r_valid_o = to_clint ? clint_r_valid_i : sram_r_valid_i;
	assign slv_b_o       = to_clint ? clint_b_i : sram_b_i;
	assign slv_b_valid_o = to_clint ? clint_b_valid_i : sram_b_valid_i;

	assign sram_r_ready_o  = slv_r_ready_i & ~to_clint;
	assign sram_b_ready_o  = slv_b_ready_i & ~to_clint;
	assign clint_r_ready_o = slv_r_ready_i & to_clint;
	assign clint_b_ready_o = slv_b_ready_i & to_clint;

endmodule

/* src/axi_arbiter.sv */
//*************************************************
// axi_arbiter: one transaction at a time from the
// fetch or load/store port, data port first
//*************************************************
`timescale 1ns/1ps
`include "axi_settings.svh"

module axi_arbiter (
	input  logic               clock,
	input  logic               reset,
	// fetch port, read only
	input  axi_pkg::addr_req_t inst_ar_i,
	input  logic               inst_ar_valid_i,
	output logic               inst_ar_ready_o,
	output axi_pkg::rdata_t    inst_r_o,
	output logic               inst_r_valid_o,
	input  logic               inst_r_ready_i,
	// load/store port
	input  axi_pkg::addr_req_t data_ar_i,
	input  logic               data_ar_valid_i,
	output logic               data_ar_ready_o,
	input  axi_pkg::addr_req_t data_aw_i,
	input  logic               data_aw_valid_i,
	output logic               data_aw_ready_o,
	input  axi_pkg::wdata_t    data_w_i,
	input  logic               data_w_valid_i,
	output logic               data_w_ready_o,
	output axi_pkg::rdata_t    data_r_o,
	output logic               data_r_valid_o,
	input  logic               data_r_ready_i,
	output axi_pkg::resp_t     data_b_o,
	output logic               data_b_valid_o,
	input  logic               data_b_ready_i,
	// shared path toward the xbar
	output axi_pkg::addr_req_t slv_ar_o,
	output logic               slv_ar_valid_o,
	input  logic               slv_ar_ready_i,
	output axi_pkg::addr_req_t slv_aw_o,
	output logic               slv_aw_valid_o,
	input  logic               slv_aw_ready_i,
	output axi_pkg::wdata_t    slv_w_o,
	output logic               slv_w_valid_o,
	input  logic               slv_w_ready_i,
	input  axi_pkg::rdata_t    slv_r_i,
	input  logic               slv_r_valid_i,
	output logic               slv_r_ready_o,
	input  axi_pkg::resp_t     slv_b_i,
	input  logic               slv_b_valid_i,
	output logic               slv_b_ready_o,
	output axi_pkg::device_t   device_sel_o
);
	import axi_pkg::*;

	arb_state_t state_q;
	arb_state_t state_d;
	device_t    device_q;      // target held while busy
	device_t    device_dec;
	addr_t      req_addr;
	logic       idle;
	logic       grant_wr;
	logic       grant_rd;
	logic       grant_inst;
	logic       accepted;
	logic       owner_done;

	assign idle = (state_q == ARB_IDLE);

	// store needs aw and w together, then load, then fetch
	assign grant_wr   = idle & data_aw_valid_i & data_w_valid_i;
	assign grant_rd   = idle & ~grant_wr & data_ar_valid_i;
	assign grant_inst = idle & ~grant_wr & ~data_ar_valid_i & inst_ar_valid_i;

	assign req_addr = grant_wr ? data_aw_i.addr :
		grant_rd ? data_ar_i.addr : inst_ar_i.addr;

	// timer region is tagged by the upper half of the address
	assign device_dec = (req_addr[`AXI_ADDR_W-1 -: 16] == `CLINT_BASE) ? DEV_CLINT : DEV_SRAM;
	assign device_sel_o = idle ? device_dec : device_q;

	assign slv_ar_o       = grant_inst ? inst_ar_i : data_ar_i;
	assign slv_ar_valid_o = grant_rd | grant_inst;
	assign slv_aw_o       = data_aw_i;
	assign slv_aw_valid_o = grant_wr;
	assign slv_w_o        = data_w_i;
	assign slv_w_valid_o  = grant_wr;

	// ready only reaches the winner, and only in the request cycle
	assign data_aw_ready_o = grant_wr & slv_aw_ready_i & slv_w_ready_i;
	assign data_w_ready_o  = data_aw_ready_o;
	assign data_ar_ready_o = grant_rd & slv_ar_ready_i;
	assign inst_ar_ready_o = grant_inst & slv_ar_ready_i;
	assign accepted = data_aw_ready_o | data_ar_ready_o | inst_ar_ready_o;

	// responses are steered to the owner, the other port sees nothing
	assign inst_r_o       = slv_r_i;
	assign inst_r_valid_o = (state_q == ARB_BUSY_INST) & slv_r_valid_i;
	assign data_r_o       = slv_r_i;
	assign data_r_valid_o = (state_q == ARB_BUSY_DATA) & slv_r_valid_i;
	assign data_b_o       = slv_b_i;
	assign data_b_valid_o = (state_q == ARB_BUSY_DATA) & slv_b_valid_i;
	assign slv_r_ready_o  = (state_q == ARB_BUSY_DATA) ? data_r_ready_i :
		(state_q == ARB_BUSY_INST) & inst_r_ready_i;
	assign slv_b_ready_o  = (state_q == ARB_BUSY_DATA) & data_b_ready_i;

	assign owner_done = (inst_r_valid_o & inst_r_ready_i) |
		(data_r_valid_o & data_r_ready_i) | (data_b_valid_o & data_b_ready_i);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				if (accepted) begin
					state_d = grant_inst ? ARB_BUSY_INST : ARB_BUSY_DATA;
				end
			end
			ARB_BUSY_DATA,
			ARB_BUSY_INST: begin
				if (owner_done) begin
					state_d = ARB_IDLE;   // free on the owner's response beat
				end
			end
			default: state_d = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q  <= ARB_IDLE;
			device_q <= DEV_SRAM;
		end else begin
			state_q <= state_d;
			if (idle && accepted) begin
				device_q <= device_dec;
			end
		end
	end

endmodule

/* src/axi_pkg.sv */
//*************************************************
// axi_pkg: channel payload types shared by the
// arbiter, the xbar and both devices
//*************************************************
`include "axi_settings.svh"

package axi_pkg;

	typedef logic [`AXI_ADDR_W-1:0]   addr_t;
	typedef logic [`AXI_DATA_W-1:0]   data_t;
	typedef logic [`AXI_DATA_W/8-1:0] strb_t;  // one bit per byte lane
	typedef logic [1:0]               resp_t;
	typedef logic [2:0]               size_t;  // log2 of bytes per beat

	// ar and aw beats look the same
	typedef struct packed {
		addr_t addr;
		size_t size;
	} addr_req_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} wdata_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
	} rdata_t;

	typedef enum logic {
		DEV_SRAM,
		DEV_CLINT
	} device_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_BUSY_DATA,   // load/store port owns the path
		ARB_BUSY_INST    // fetch port owns the path
	} arb_state_t;

endpackage

/* src/axi_settings.svh */
//*************************************************
// bus settings: widths, SRAM depth and latency,
// CLINT region tag and response codes
//*************************************************
`ifndef AXI_SETTINGS_SVH
`define AXI_SETTINGS_SVH

`define AXI_ADDR_W    32
`define AXI_DATA_W    32

// on-chip SRAM model
`define SRAM_WORDS    256
`define SRAM_LATENCY  3      // address accept to response valid, must be >= 1

// upper 16 address bits of the timer region
`define CLINT_BASE    16'h0200

`define RESP_OKAY     2'b00
`define RESP_SLVERR   2'b10

`endif
